/* include/decode_cfg.svh */
`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

// register file geometry
`define DECODE_XLEN      32
`define DECODE_REG_COUNT 32
`define DECODE_REG_BITS  5

// fetch response buffer entries
`define DECODE_BUF_DEPTH 2

`endif

/* logic/decode_pkg.sv */
package decode_pkg;

    // major opcodes handled by this decoder
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_reg_view_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_imm_view_t;

    // same word, R-type or I-type field layout
    typedef union packed {
        rv_reg_view_t r;
        rv_imm_view_t i;
    } rv_instruction_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_LUI
    } alu_op_t;

    typedef enum logic [0:0] {
        SYS_ECALL,
        SYS_EBREAK
    } system_op_t;

endpackage

/* logic/instruction_buffer.sv */
`timescale 1ns/1ns
`include "decode_cfg.svh"

module instruction_buffer (
    input  logic        clk,
    input  logic        rst,
    input  logic        in_valid,
    output logic        in_ready,
    input  logic [31:0] in_data,
    input  logic        in_last,
    output logic        out_valid,
    input  logic        out_ready,
    output logic [31:0] out_data
);

    localparam int DEPTH    = `DECODE_BUF_DEPTH;
    localparam int PTR_BITS = $clog2(DEPTH);
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    logic [31:0]         entries [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic                push;
    logic                pop;

    // ready comes from state only, no path back from the decoder
    assign in_ready  = count < CNT_BITS'(DEPTH);
    assign out_valid = count != '0;
    assign out_data  = entries[rd_ptr];

    assign push = in_valid && in_ready && in_last; // partial beats are dropped
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            count <= count + CNT_BITS'(push) - CNT_BITS'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) entries[wr_ptr] <= in_data;
    end

endmodule

/* logic/instruction_decoder.sv */
`timescale 1ns/1ns
`include "decode_cfg.svh"

module instruction_decoder (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         word_valid,
    output logic                         word_ready,
    input  decode_pkg::rv_instruction_t  word,
    output logic                         dec_valid,
    input  logic                         dec_ready,
    output decode_pkg::alu_op_t          alu_op,
    output logic [`DECODE_REG_BITS-1:0]  rd,
    output logic [`DECODE_REG_BITS-1:0]  rs1,
    output logic [`DECODE_REG_BITS-1:0]  rs2,
    output logic [`DECODE_XLEN-1:0]      imm,
    output logic                         uses_imm,
    output logic                         reg_write,
    output logic                         is_system,
    output decode_pkg::system_op_t       sys_op,
    output logic                         illegal
);
    import decode_pkg::*;

    alu_op_t                     next_alu_op;
    logic [`DECODE_REG_BITS-1:0] next_rs1;
    logic [`DECODE_XLEN-1:0]     next_imm;
    logic [`DECODE_XLEN-1:0]     imm_i;
    logic [`DECODE_XLEN-1:0]     shamt;
    logic                        next_uses_imm;
    logic                        next_reg_write;
    logic                        next_is_system;
    system_op_t                  next_sys_op;
    logic                        next_illegal;
    logic                        accept;

    assign word_ready = !dec_valid || dec_ready;
    assign accept     = word_valid && word_ready;
    assign imm_i      = {{(`DECODE_XLEN-12){word.i.imm12[11]}}, word.i.imm12};
    assign shamt      = {{(`DECODE_XLEN-5){1'b0}}, word.r.rs2}; // shift amount sits in rs2 slot

    always_comb begin
        next_alu_op    = ALU_ADD;
        next_rs1       = word.i.rs1;
        next_imm       = imm_i;
        next_uses_imm  = 1'b1;
        next_reg_write = 1'b1;
        next_is_system = 1'b0;
        next_sys_op    = SYS_ECALL;
        next_illegal   = 1'b0;
        case (word.r.opcode)
            OPC_OP: begin
                next_uses_imm = 1'b0;
                case ({word.r.funct7, word.r.funct3})
                    {7'h00, 3'b000}: next_alu_op = ALU_ADD;
                    {7'h20, 3'b000}: next_alu_op = ALU_SUB;
                    {7'h00, 3'b001}: next_alu_op = ALU_SLL;
                    {7'h00, 3'b010}: next_alu_op = ALU_SLT;
                    {7'h00, 3'b011}: next_alu_op = ALU_SLTU;
                    {7'h00, 3'b100}: next_alu_op = ALU_XOR;
                    {7'h00, 3'b101}: next_alu_op = ALU_SRL;
                    {7'h20, 3'b101}: next_alu_op = ALU_SRA;
                    {7'h00, 3'b110}: next_alu_op = ALU_OR;
                    {7'h00, 3'b111}: next_alu_op = ALU_AND;
                    default:         next_illegal = 1'b1;
                endcase
            end
            OPC_OP_IMM: begin
                case (word.i.funct3)
                    3'b000: next_alu_op = ALU_ADD;
                    3'b010: next_alu_op = ALU_SLT;
                    3'b011: next_alu_op = ALU_SLTU;
                    3'b100: next_alu_op = ALU_XOR;
                    3'b110: next_alu_op = ALU_OR;
                    3'b111: next_alu_op = ALU_AND;
                    3'b001: begin
                        next_alu_op  = ALU_SLL;
                        next_imm     = shamt;
                        next_illegal = word.r.funct7 != 7'h00;
                    end
                    default: begin // 3'b101, srli or srai
                        next_alu_op  = (word.r.funct7 == 7'h20) ? ALU_SRA : ALU_SRL;
                        next_imm     = shamt;
                        next_illegal = word.r.funct7 != 7'h00 && word.r.funct7 != 7'h20;
                    end
                endcase
            end
            OPC_LUI: begin
                next_alu_op = ALU_LUI;
                next_rs1    = '0; // no source, never stalls
                next_imm    = {word.i.imm12, word.i.rs1, word.i.funct3, 12'b0};
            end
            OPC_SYSTEM: begin
                next_is_system = 1'b1;
                next_reg_write = 1'b0;
                next_rs1       = '0;
                next_sys_op    = word.i.imm12[0] ? SYS_EBREAK : SYS_ECALL;
                next_illegal   = word.i.imm12[11:1] != '0 || word.i.rs1 != '0 ||
                                 word.i.funct3 != '0 || word.i.rd != '0;
            end
            default: next_illegal = 1'b1; // branches, jumps, loads, stores and the rest
        endcase
        if (next_illegal) next_reg_write = 1'b0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else if (word_ready) begin
            dec_valid <= word_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            alu_op    <= next_alu_op;
            rd        <= word.i.rd;
            rs1       <= next_rs1;
            rs2       <= word.r.rs2;
            imm       <= next_imm;
            uses_imm  <= next_uses_imm;
            reg_write <= next_reg_write;
            is_system <= next_is_system;
            sys_op    <= next_sys_op;
            illegal   <= next_illegal;
        end
    end

endmodule

/* logic/register_scoreboard.sv */
`timescale 1ns/1ns
`include "decode_cfg.svh"

module register_scoreboard (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [`DECODE_REG_BITS-1:0] rs1,
    input  logic [`DECODE_REG_BITS-1:0] rs2,
    output logic [`DECODE_XLEN-1:0]     rs1_data,
    output logic [`DECODE_XLEN-1:0]     rs2_data,
    output logic                        rs1_pending,
    output logic                        rs2_pending,
    input  logic                        set_pending,
    input  logic [`DECODE_REG_BITS-1:0] set_rd,
    input  logic                        wb_valid,
    input  logic [`DECODE_REG_BITS-1:0] wb_rd,
    input  logic [`DECODE_XLEN-1:0]     wb_data
);

    logic [`DECODE_XLEN-1:0]      regs [`DECODE_REG_COUNT];
    logic [`DECODE_REG_COUNT-1:0] pending;
    logic                         wb_write;
    logic                         set_write;

    assign wb_write  = wb_valid && wb_rd != '0;    // x0 stays zero
    assign set_write = set_pending && set_rd != '0;

    // combinational reads for the issue stage
    assign rs1_data    = regs[rs1];
    assign rs2_data    = regs[rs2];
    assign rs1_pending = pending[rs1];
    assign rs2_pending = pending[rs2];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `DECODE_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_write) begin
            regs[wb_rd] <= wb_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '0;
        end else begin
            if (wb_write) pending[wb_rd] <= 1'b0;
            // set after clear so a newer writer of the same register stays pending
            if (set_write) pending[set_rd] <= 1'b1;
        end
    end

endmodule

/* logic/issue_stage.sv */
`timescale 1ns/1ns
`include "decode_cfg.svh"

module issue_stage (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        dec_valid,
    output logic                        dec_ready,
    input  decode_pkg::alu_op_t         dec_alu_op,
    input  logic [`DECODE_REG_BITS-1:0] dec_rd,
    input  logic [`DECODE_XLEN-1:0]     dec_imm,
    input  logic                        dec_uses_imm,
    input  logic                        dec_reg_write,
    input  logic                        dec_is_system,
    input  decode_pkg::system_op_t      dec_sys_op,
    input  logic                        dec_illegal,
    input  logic [`DECODE_XLEN-1:0]     rs1_data,
    input  logic [`DECODE_XLEN-1:0]     rs2_data,
    input  logic                        rs1_pending,
    input  logic                        rs2_pending,
    output logic                        set_pending,
    output logic [`DECODE_REG_BITS-1:0] set_rd,
    output logic                        execute_valid,
    input  logic                        execute_ready,
    output decode_pkg::alu_op_t         alu_op,
    output logic [`DECODE_REG_BITS-1:0] rd,
    output logic [`DECODE_XLEN-1:0]     operand_a,
    output logic [`DECODE_XLEN-1:0]     operand_b,
    output logic                        reg_write,
    output logic                        system_valid,
    input  logic                        system_ready,
    output decode_pkg::system_op_t      sys_op,
    output logic                        exit_flag,
    output logic                        error_flag
);
    import decode_pkg::*;

    logic out_free;
    logic stall;
    logic fire;
    logic to_execute;

    assign out_free   = !(execute_valid && !execute_ready) && !(system_valid && !system_ready);
    assign stall      = rs1_pending || (!dec_uses_imm && rs2_pending); // rs2 only if no imm
    assign dec_ready  = dec_illegal || (out_free && !stall);
    assign fire       = dec_valid && dec_ready;
    assign to_execute = fire && !dec_illegal && !dec_is_system;

    assign set_pending = to_execute && dec_reg_write && dec_rd != '0;
    assign set_rd      = dec_rd;

    always_ff @(posedge clk) begin
        if (rst) begin
            execute_valid <= 1'b0;
            system_valid  <= 1'b0;
            exit_flag     <= 1'b0;
            error_flag    <= 1'b0;
        end else begin
            if (execute_ready) execute_valid <= 1'b0;
            if (system_ready) system_valid <= 1'b0;
            if (to_execute) execute_valid <= 1'b1;
            if (fire && dec_illegal) error_flag <= 1'b1; // consumed, nothing dispatched
            if (fire && !dec_illegal && dec_is_system) begin
                system_valid <= 1'b1;
                if (dec_sys_op == SYS_ECALL) exit_flag <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (to_execute) begin
            alu_op    <= dec_alu_op;
            rd        <= dec_rd;
            operand_a <= rs1_data;
            operand_b <= dec_uses_imm ? dec_imm : rs2_data;
            reg_write <= dec_reg_write;
        end
        if (fire && !dec_illegal && dec_is_system) sys_op <= dec_sys_op;
    end

endmodule

/* logic/decode_top.sv */
`timescale 1ns/1ns
`include "decode_cfg.svh"

module decode_top (
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        instruction_result_valid,
    output logic                        instruction_result_ready,
    input  logic [31:0]                 instruction_result_data,
    input  logic                        instruction_result_last,

    input  logic                        writeback_result_valid,
    output logic                        writeback_result_ready,
    input  logic [`DECODE_REG_BITS-1:0] writeback_result_rd,
    input  logic [`DECODE_XLEN-1:0]     writeback_result_data,

    output logic                        execute_command_valid,
    input  logic                        execute_command_ready,
    output decode_pkg::alu_op_t         execute_command_alu_op,
    output logic [`DECODE_REG_BITS-1:0] execute_command_rd,
    output logic [`DECODE_XLEN-1:0]     execute_command_operand_a,
    output logic [`DECODE_XLEN-1:0]     execute_command_operand_b,
    output logic                        execute_command_reg_write,

    output logic                        system_command_valid,
    input  logic                        system_command_ready,
    output decode_pkg::system_op_t      system_command_sys_op,

    output logic                        exit_flag,
    output logic                        error_flag
);
    import decode_pkg::*;

    logic                        word_valid;
    logic                        word_ready;
    logic [31:0]                 word;
    logic                        dec_valid;
    logic                        dec_ready;
    alu_op_t                     dec_alu_op;
    logic [`DECODE_REG_BITS-1:0] dec_rd;
    logic [`DECODE_REG_BITS-1:0] dec_rs1;
    logic [`DECODE_REG_BITS-1:0] dec_rs2;
    logic [`DECODE_XLEN-1:0]     dec_imm;
    logic                        dec_uses_imm;
    logic                        dec_reg_write;
    logic                        dec_is_system;
    system_op_t                  dec_sys_op;
    logic                        dec_illegal;
    logic [`DECODE_XLEN-1:0]     rs1_data;
    logic [`DECODE_XLEN-1:0]     rs2_data;
    logic                        rs1_pending;
    logic                        rs2_pending;
    logic                        set_pending;
    logic [`DECODE_REG_BITS-1:0] set_rd;

    always_comb writeback_result_ready = 1'b1; // register file always takes results

    instruction_buffer buffer0 (
        .clk,
        .rst,
        .in_valid  (instruction_result_valid),
        .in_ready  (instruction_result_ready),
        .in_data   (instruction_result_data),
        .in_last   (instruction_result_last),
        .out_valid (word_valid),
        .out_ready (word_ready),
        .out_data  (word)
    );

    instruction_decoder decoder0 (
        .clk,
        .rst,
        .word_valid,
        .word_ready,
        .word,
        .dec_valid,
        .dec_ready,
        .alu_op    (dec_alu_op),
        .rd        (dec_rd),
        .rs1       (dec_rs1),
        .rs2       (dec_rs2),
        .imm       (dec_imm),
        .uses_imm  (dec_uses_imm),
        .reg_write (dec_reg_write),
        .is_system (dec_is_system),
        .sys_op    (dec_sys_op),
        .illegal   (dec_illegal)
    );

    register_scoreboard scoreboard0 (
        .clk,
        .rst,
        .rs1      (dec_rs1),
        .rs2      (dec_rs2),
        .rs1_data,
        .rs2_data,
        .rs1_pending,
        .rs2_pending,
        .set_pending,
        .set_rd,
        .wb_valid (writeback_result_valid),
        .wb_rd    (writeback_result_rd),
        .wb_data  (writeback_result_data)
    );

    issue_stage issue0 (
        .clk,
        .rst,
        .dec_valid,
        .dec_ready,
        .dec_alu_op,
        .dec_rd,
        .dec_imm,
        .dec_uses_imm,
        .dec_reg_write,
        .dec_is_system,
        .dec_sys_op,
        .dec_illegal,
        .rs1_data,
        .rs2_data,
        .rs1_pending,
        .rs2_pending,
        .set_pending,
        .set_rd,
        .execute_valid (execute_command_valid),
        .execute_ready (execute_command_ready),
        .alu_op        (execute_command_alu_op),
        .rd            (execute_command_rd),
        .operand_a     (execute_command_operand_a),
        .operand_b     (execute_command_operand_b),
        .reg_write     (execute_command_reg_write),
        .system_valid  (system_command_valid),
        .system_ready  (system_command_ready),
        .sys_op        (system_command_sys_op),
        .exit_flag,
        .error_flag
    );

endmodule

/* tests/decode_checker.sv */
`timescale 1ns/1ns

module decode_checker #(
    parameter int N = 12,
    parameter int TIMEOUT = 2000
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        exec_valid,
    input  logic        exec_ready,
    input  logic [3:0]  exec_alu_op,
    input  logic [4:0]  exec_rd,
    input  logic [31:0] exec_a,
    input  logic [31:0] exec_b,
    input  logic        exec_reg_write,
    input  logic        sys_valid,
    input  logic        sys_ready,
    input  logic        sys_op,
    input  logic        exit_flag,
    input  logic        error_flag,
    input  logic [95:0] names [N],
    input  logic [1:0]  kinds [N],    // 0 execute, 1 system, 2 nothing dispatched
    input  logic [3:0]  alu_ops [N],
    input  logic [4:0]  rds [N],
    input  logic [31:0] as [N],
    input  logic [31:0] bs [N],
    input  logic        sys_ops [N],
    output int          seen,
    output int          failures,
    output logic        finished
);

    function automatic string name_of(input logic [95:0] packed_name);
        string s;
        s = "";
        for (int k = 11; k >= 0; k--) begin
            if (packed_name[k*8 +: 8] != 8'h00) s = {s, $sformatf("%c", packed_name[k*8 +: 8])};
        end
        return s;
    endfunction

    task automatic compare(input string name, input string field, input logic [31:0] exp,
                           input logic [31:0] act, inout logic bad);
        if (exp !== act) begin
            $display("ERROR %s %s expected %h actual %h", name, field, exp, act);
            bad = 1'b1;
        end
    endtask

    initial begin
        int   waited;
        logic got;
        logic got_exec;
        logic bad;
        logic stop;
        string name;
        seen     = 0;
        failures = 0;
        finished = 1'b0;
        stop     = 1'b0;
        waited   = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (rst && waited < TIMEOUT);
        if (rst) begin
            $display("timeout waiting for reset to be released");
            failures++;
            stop = 1'b1;
        end else if (exec_valid || sys_valid || exit_flag || error_flag) begin
            $display("outputs or flags not low after reset");
            failures++;
        end
        for (int i = 0; i < N && !stop; i++) begin
            name   = name_of(names[i]);
            bad    = 1'b0;
            got    = 1'b0;
            waited = 0;
            if (kinds[i] == 2'd2) begin
                while (!error_flag && waited < TIMEOUT) begin
                    @(posedge clk);
                    waited++;
                    if ((exec_valid && exec_ready) || (sys_valid && sys_ready)) begin
                        $display("%s produced a dispatch but should have been dropped", name);
                        bad = 1'b1;
                    end
                end
                if (!error_flag) begin
                    $display("timeout waiting for error_flag on %s", name);
                    bad  = 1'b1;
                    stop = 1'b1;
                end
                compare(name, "exit_flag", 32'd0, {31'd0, exit_flag}, bad);
            end else begin
                got_exec = 1'b0;
                while (!got && waited < TIMEOUT) begin
                    @(posedge clk);
                    waited++;
                    if (exec_valid && exec_ready) begin
                        got      = 1'b1;
                        got_exec = 1'b1;
                    end else if (sys_valid && sys_ready) begin
                        got = 1'b1;
                    end
                end
                if (!got) begin
                    $display("timeout waiting for a dispatch of %s", name);
                    bad  = 1'b1;
                    stop = 1'b1;
                end else if (got_exec != (kinds[i] == 2'd0)) begin
                    $display("%s dispatched on the wrong output stream", name);
                    bad = 1'b1;
                end else if (got_exec) begin
                    compare(name, "alu_op", {28'd0, alu_ops[i]}, {28'd0, exec_alu_op}, bad);
                    compare(name, "rd", {27'd0, rds[i]}, {27'd0, exec_rd}, bad);
                    compare(name, "operand_a", as[i], exec_a, bad);
                    compare(name, "operand_b", bs[i], exec_b, bad);
                    // every tabled ALU op writes its rd
                    compare(name, "reg_write", 32'd1, {31'd0, exec_reg_write}, bad);
                end else begin
                    compare(name, "sys_op", {31'd0, sys_ops[i]}, {31'd0, sys_op}, bad);
                    // ecall raises exit on the same edge as system valid
                    if (sys_ops[i] == 1'b0) begin
                        compare(name, "exit_flag", 32'd1, {31'd0, exit_flag}, bad);
                    end
                end
            end
            if (bad) begin
                $display("FAIL %s", name);
                failures++;
            end else begin
                $display("PASS %s", name);
            end
            seen++;
        end
        finished = 1'b1;
    end

endmodule

/* tests/decode_tb.sv */
`timescale 1ns/1ns

module decode_tb;
    import decode_pkg::*;

    localparam int N = 12;
    localparam int TIMEOUT = 2000;

    logic        clk;
    logic        rst;
    logic        ir_valid;
    logic        ir_ready;
    logic [31:0] ir_data;
    logic        ir_last;
    logic        wb_valid;
    logic        wb_ready;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic        exec_valid;
    logic        exec_ready;
    alu_op_t     exec_alu_op;
    logic [4:0]  exec_rd;
    logic [31:0] exec_a;
    logic [31:0] exec_b;
    logic        exec_reg_write;
    logic        sys_valid;
    logic        sys_ready;
    system_op_t  sys_op;
    logic        exit_flag;
    logic        error_flag;

    logic [95:0] names [N];
    logic [31:0] words [N];
    int          wb_count [N];
    logic [4:0]  wb_rds [N][2];
    logic [31:0] wb_values [N][2];
    logic        late_wb [N];     // writeback only after checking the stall
    logic [1:0]  kinds [N];
    logic [3:0]  alu_ops [N];
    logic [4:0]  rds [N];
    logic [31:0] as [N];
    logic [31:0] bs [N];
    logic        sys_ops [N];

    int     n_entries;
    int     seen;
    int     failures;
    int     tb_failures;
    logic   finished;
    logic   timed_out;
    integer seed;

    always #4 clk = ~clk;

    // random back-pressure on both outputs
    always @(posedge clk) begin
        exec_ready <= 1'($random(seed));
        sys_ready  <= 1'($random(seed));
    end

    decode_top dut0 (
        .clk,
        .rst,
        .instruction_result_valid  (ir_valid),
        .instruction_result_ready  (ir_ready),
        .instruction_result_data   (ir_data),
        .instruction_result_last   (ir_last),
        .writeback_result_valid    (wb_valid),
        .writeback_result_ready    (wb_ready),
        .writeback_result_rd       (wb_rd),
        .writeback_result_data     (wb_data),
        .execute_command_valid     (exec_valid),
        .execute_command_ready     (exec_ready),
        .execute_command_alu_op    (exec_alu_op),
        .execute_command_rd        (exec_rd),
        .execute_command_operand_a (exec_a),
        .execute_command_operand_b (exec_b),
        .execute_command_reg_write (exec_reg_write),
        .system_command_valid      (sys_valid),
        .system_command_ready      (sys_ready),
        .system_command_sys_op     (sys_op),
        .exit_flag,
        .error_flag
    );

    decode_checker #(.N(N), .TIMEOUT(TIMEOUT)) checker0 (
        .clk, .rst, .exec_valid, .exec_ready, .exec_alu_op, .exec_rd, .exec_a, .exec_b,
        .exec_reg_write, .sys_valid, .sys_ready, .sys_op, .exit_flag, .error_flag,
        .names, .kinds, .alu_ops, .rds, .as, .bs, .sys_ops,
        .seen, .failures, .finished
    );

    // RV32I field layouts
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    task automatic add_entry(input logic [95:0] name, input logic [31:0] word, input int nwb,
                             input logic [4:0] r0, input logic [31:0] d0,
                             input logic [4:0] r1, input logic [31:0] d1, input logic late,
                             input logic [1:0] kind, input logic [3:0] op, input logic [4:0] rd,
                             input logic [31:0] a, input logic [31:0] b, input logic sop);
        names[n_entries]        = name;
        words[n_entries]        = word;
        wb_count[n_entries]     = nwb;
        wb_rds[n_entries][0]    = r0;
        wb_values[n_entries][0] = d0;
        wb_rds[n_entries][1]    = r1;
        wb_values[n_entries][1] = d1;
        late_wb[n_entries]      = late;
        kinds[n_entries]        = kind;
        alu_ops[n_entries]      = op;
        rds[n_entries]          = rd;
        as[n_entries]           = a;
        bs[n_entries]           = b;
        sys_ops[n_entries]      = sop;
        n_entries++;
    endtask

    task automatic send_word(input logic [31:0] data, input logic last);
        int waited;
        waited = 0;
        @(posedge clk);
        ir_valid <= 1'b1;
        ir_data  <= data;
        ir_last  <= last;
        do begin
            @(posedge clk);
            waited++;
        end while (!ir_ready && waited < TIMEOUT);
        if (!ir_ready) begin
            $display("timeout waiting for instruction_result_ready");
            timed_out = 1'b1;
        end
        ir_valid <= 1'b0;
    endtask

    task automatic write_back(input logic [4:0] rd, input logic [31:0] data);
        int waited;
        waited = 0;
        @(posedge clk);
        wb_valid <= 1'b1;
        wb_rd    <= rd;
        wb_data  <= data;
        do begin
            @(posedge clk);
            waited++;
        end while (!wb_ready && waited < TIMEOUT);
        if (!wb_ready) begin
            $display("timeout waiting for writeback_result_ready");
            timed_out = 1'b1;
        end
        wb_valid <= 1'b0;
    endtask

    task automatic wait_seen(input int target);
        int waited;
        waited = 0;
        while (seen < target && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (seen < target) begin
            $display("timeout waiting for test %0d to complete", target - 1);
            timed_out = 1'b1;
        end
    endtask

    initial begin
        int waited;
        clk         = 1'b0;
        rst         = 1'b1;
        ir_valid    = 1'b0;
        ir_data     = '0;
        ir_last     = 1'b0;
        wb_valid    = 1'b0;
        wb_rd       = '0;
        wb_data     = '0;
        exec_ready  = 1'b0;
        sys_ready   = 1'b0;
        seed        = 32'h032d_0313;
        n_entries   = 0;
        tb_failures = 0;
        timed_out   = 1'b0;

        add_entry("add", r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd10), 2, 5'd1, 32'h0000_1234,
                  5'd2, 32'h0000_0100, 0, 2'd0, ALU_ADD, 5'd10, 32'h0000_1234, 32'h0000_0100, 0);
        add_entry("sub", r_type(7'h20, 5'd4, 5'd3, 3'b000, 5'd11), 2, 5'd3, 32'h8000_0000,
                  5'd4, 32'h0000_0001, 0, 2'd0, ALU_SUB, 5'd11, 32'h8000_0000, 32'h0000_0001, 0);
        add_entry("and", r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd12), 0, 5'd0, 0, 5'd0, 0, 0,
                  2'd0, ALU_AND, 5'd12, 32'h0000_1234, 32'h0000_0100, 0);
        add_entry("sra", r_type(7'h20, 5'd4, 5'd3, 3'b101, 5'd13), 0, 5'd0, 0, 5'd0, 0, 0,
                  2'd0, ALU_SRA, 5'd13, 32'h8000_0000, 32'h0000_0001, 0);
        add_entry("sltu", r_type(7'h00, 5'd3, 5'd4, 3'b011, 5'd14), 0, 5'd0, 0, 5'd0, 0, 0,
                  2'd0, ALU_SLTU, 5'd14, 32'h0000_0001, 32'h8000_0000, 0);
        add_entry("addi_neg", i_type(12'hfff, 5'd1, 3'b000, 5'd15), 0, 5'd0, 0, 5'd0, 0, 0,
                  2'd0, ALU_ADD, 5'd15, 32'h0000_1234, 32'hffff_ffff, 0);
        add_entry("lui", {20'habcde, 5'd16, 7'b0110111}, 0, 5'd0, 0, 5'd0, 0, 0,
                  2'd0, ALU_LUI, 5'd16, 32'h0, 32'habcd_e000, 0);
        add_entry("addi_x0", i_type(12'h005, 5'd0, 3'b000, 5'd17), 1, 5'd0, 32'h0000_0055,
                  5'd0, 0, 0, 2'd0, ALU_ADD, 5'd17, 32'h0, 32'h0000_0005, 0);
        add_entry("xori", i_type(12'h0f0, 5'd1, 3'b100, 5'd19), 0, 5'd0, 0, 5'd0, 0, 0,
                  2'd0, ALU_XOR, 5'd19, 32'h0000_1234, 32'h0000_00f0, 0);
        add_entry("stall_rd", i_type(12'h003, 5'd19, 3'b000, 5'd20), 1, 5'd19, 32'h0000_0777,
                  5'd0, 0, 1, 2'd0, ALU_ADD, 5'd20, 32'h0000_0777, 32'h0000_0003, 0);
        add_entry("jal_illegal", 32'h0000_006f, 0, 5'd0, 0, 5'd0, 0, 0,
                  2'd2, ALU_ADD, 5'd0, 0, 0, 0);
        add_entry("ecall", 32'h0000_0073, 0, 5'd0, 0, 5'd0, 0, 0,
                  2'd1, ALU_ADD, 5'd0, 0, 0, SYS_ECALL);

        repeat (10) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < n_entries; i++) begin
            if (timed_out) break;
            if (wb_count[i] > 0 && !late_wb[i]) begin
                wait_seen(i); // earlier readers must have their operands first
                for (int w = 0; w < wb_count[i]; w++) write_back(wb_rds[i][w], wb_values[i][w]);
            end
            send_word(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd21), 1'b0); // partial, dropped
            send_word(words[i], 1'b1);
            if (late_wb[i] && !timed_out) begin
                wait_seen(i);
                repeat (5) @(posedge clk);
                if (seen != i) begin
                    $display("%0d dispatches seen before the pending source was written", seen);
                    tb_failures++;
                end
                write_back(wb_rds[i][0], wb_values[i][0]);
            end
        end

        waited = 0;
        while (!finished && !timed_out && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (!finished) begin
            $display("timeout waiting for the checker to finish");
            timed_out = 1'b1;
        end
        $display("%0d tests checked, %0d failed", seen, failures + tb_failures);
        if (failures == 0 && tb_failures == 0 && !timed_out) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+include
logic/decode_pkg.sv
logic/instruction_buffer.sv
logic/instruction_decoder.sv
logic/register_scoreboard.sv
logic/issue_stage.sv
logic/decode_top.sv
tests/decode_checker.sv
tests/decode_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = decode_tb
FILELIST  = filelist.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
